// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbMipsCpu
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILE_LIST ?= compile.f
VFLAGS ?= --binary --assert --timing

SRCS := $(shell grep -v '^+' $(FILE_LIST))
HDRS := logic/cpuSettings.svh
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+logic
logic/cpuPkg.sv
logic/fetchUnit.sv
logic/decodeStage.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/mipsCpu.sv
sim/tbClock.sv
sim/tbMipsCpu.sv

// ==== logic/cpuPkg.sv ====
`include "cpuSettings.svh"

package cpuPkg;

	// Decoded instruction, opcNop covers everything outside the subset
	typedef enum logic [3:0] {
		opcNop,
		opcAddu,
		opcSubu,
		opcOri,
		opcLui,
		opcLw,
		opcSw,
		opcBeq,
		opcJ,
		opcJal,
		opcJr
	} opcodeT;

	typedef enum logic [1:0] {
		aluAdd,
		aluSub,
		aluOr,
		aluLui
	} aluOpT;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbLink
	} wbSrcT;

	// Tuse or Tnew, in cycles counted from decode
	typedef logic [1:0] tClassT;

	typedef enum logic [1:0] {
		fwdRf,
		fwdMem,
		fwdWb
	} fwdSelT;

	// Operand pick shared by decode and execute
	function automatic logic [`DATA_W-1:0] fwdMux(
		input fwdSelT sel,
		input logic [`DATA_W-1:0] rfVal,
		input logic [`DATA_W-1:0] memVal,
		input logic [`DATA_W-1:0] wbVal
	);
		case (sel)
			fwdMem: return memVal;
			fwdWb: return wbVal;
			default: return rfVal;
		endcase
	endfunction

endpackage

// ==== logic/cpuSettings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath word
`define DATA_W 32

// Register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// First fetch after reset
`define RESET_PC 32'h3000

// Written by jal
`define LINK_REG 5'd31

`endif

// ==== logic/decodeStage.sv ====
`timescale 1ns/10ps
`include "cpuSettings.svh"

module decodeStage (
	input logic clk,
	input logic arstN,
	input logic stall,
	input logic [`DATA_W-1:0] instData,
	input logic [`DATA_W-1:0] pcPlus4F,
	input logic [`DATA_W-1:0] rfRd1,
	input logic [`DATA_W-1:0] rfRd2,
	input cpuPkg::fwdSelT fwdSel1,
	input cpuPkg::fwdSelT fwdSel2,
	input logic [`DATA_W-1:0] memFwdVal,
	input logic [`DATA_W-1:0] wbFwdVal,
	output logic [`REG_ADDR_W-1:0] rs,
	output logic [`REG_ADDR_W-1:0] rt,
	output logic [`REG_ADDR_W-1:0] dest,
	output cpuPkg::opcodeT opD,
	output cpuPkg::aluOpT aluOp,
	output cpuPkg::wbSrcT wbSrc,
	output logic regWr,
	output logic memWr,
	output cpuPkg::tClassT tUseRs,
	output cpuPkg::tClassT tUseRt,
	output cpuPkg::tClassT tNew,
	output logic [`DATA_W-1:0] imm32,
	output logic [`DATA_W-1:0] opA,
	output logic [`DATA_W-1:0] opB,
	output logic [`DATA_W-1:0] linkAddr,
	output logic branchTaken,
	output logic [`DATA_W-1:0] branchTarget,
	output logic jumpReg,
	output logic [`DATA_W-1:0] regTarget
);

	import cpuPkg::*;

	logic [`DATA_W-1:0] instrD;
	logic [`DATA_W-1:0] pcPlus4D;
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [15:0] imm16;
	logic regWrRaw;

	////////////////////////////////////////
	// Fetch/decode register
	////////////////////////////////////////

	// All zeros decodes as a no-op
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			instrD <= '0;
		end else if (!stall) begin
			instrD <= instData;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pcPlus4D <= pcPlus4F;
		end
	end

	////////////////////////////////////////
	// Decoder
	////////////////////////////////////////

	assign opcode = instrD[31:26];
	assign funct = instrD[5:0];
	assign imm16 = instrD[15:0];
	assign rs = instrD[25:21];
	assign rt = instrD[20:16];

	always_comb begin
		case (opcode)
			6'b000000: begin
				case (funct)
					6'b100001: opD = opcAddu;
					6'b100011: opD = opcSubu;
					6'b001000: opD = opcJr;
					default: opD = opcNop;
				endcase
			end
			6'b001101: opD = opcOri;
			6'b001111: opD = opcLui;
			6'b100011: opD = opcLw;
			6'b101011: opD = opcSw;
			6'b000100: opD = opcBeq;
			6'b000010: opD = opcJ;
			6'b000011: opD = opcJal;
			default: opD = opcNop;
		endcase
	end

	// Tuse of 3 marks an unused source, it can never trigger a stall
	always_comb begin
		aluOp = aluAdd;
		wbSrc = wbAlu;
		regWrRaw = 1'b0;
		memWr = 1'b0;
		dest = rt;
		tUseRs = 2'd3;
		tUseRt = 2'd3;
		tNew = 2'd0;
		case (opD)
			opcAddu, opcSubu: begin
				aluOp = (opD == opcSubu) ? aluSub : aluAdd;
				regWrRaw = 1'b1;
				dest = instrD[15:11];
				tUseRs = 2'd1;
				tUseRt = 2'd1;
				tNew = 2'd1;
			end
			opcOri: begin
				aluOp = aluOr;
				regWrRaw = 1'b1;
				tUseRs = 2'd1;
				tNew = 2'd1;
			end
			opcLui: begin
				aluOp = aluLui;
				regWrRaw = 1'b1;
				tNew = 2'd1;
			end
			opcLw: begin
				wbSrc = wbMem;
				regWrRaw = 1'b1;
				tUseRs = 2'd1;
				tNew = 2'd2;
			end
			opcSw: begin
				memWr = 1'b1;
				tUseRs = 2'd1;
				tUseRt = 2'd2;
			end
			opcBeq: begin
				tUseRs = 2'd0;
				tUseRt = 2'd0;
			end
			opcJal: begin
				wbSrc = wbLink;
				regWrRaw = 1'b1;
				dest = `LINK_REG;
			end
			opcJr: tUseRs = 2'd0;
			default: ;
		endcase
	end

	// Writes to $0 are dropped here, so no later stage sees them
	assign regWr = regWrRaw && (dest != '0);

	// ori and lui take the immediate unsigned
	assign imm32 = (opD == opcOri || opD == opcLui) ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};

	////////////////////////////////////////
	// Operands and control flow
	////////////////////////////////////////

	assign opA = fwdMux(fwdSel1, rfRd1, memFwdVal, wbFwdVal);
	assign opB = fwdMux(fwdSel2, rfRd2, memFwdVal, wbFwdVal);

	assign branchTaken = (opD == opcBeq && opA == opB) || opD == opcJ || opD == opcJal;
	assign branchTarget = (opD == opcBeq) ? pcPlus4D + {imm32[`DATA_W-3:0], 2'b00}
		: {pcPlus4D[`DATA_W-1:28], instrD[25:0], 2'b00};

	assign jumpReg = (opD == opcJr);
	assign regTarget = opA;

	// PC + 8, past the delay slot
	assign linkAddr = pcPlus4D + `DATA_W'(4);

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/10ps
`include "cpuSettings.svh"

module executeStage (
	input logic clk,
	input logic arstN,
	input logic bubble,
	input logic [`REG_ADDR_W-1:0] rs,
	input logic [`REG_ADDR_W-1:0] rt,
	input logic [`REG_ADDR_W-1:0] dest,
	input cpuPkg::opcodeT opD,
	input cpuPkg::aluOpT aluOp,
	input cpuPkg::wbSrcT wbSrc,
	input logic regWr,
	input logic memWr,
	input cpuPkg::tClassT tNew,
	input logic [`DATA_W-1:0] opA,
	input logic [`DATA_W-1:0] opB,
	input logic [`DATA_W-1:0] imm32,
	input logic [`DATA_W-1:0] linkAddr,
	input cpuPkg::fwdSelT fwdSelRs,
	input cpuPkg::fwdSelT fwdSelRt,
	input logic [`DATA_W-1:0] memFwdVal,
	input logic [`DATA_W-1:0] wbFwdVal,
	output logic [`REG_ADDR_W-1:0] rsE,
	output logic [`REG_ADDR_W-1:0] rtE,
	output logic [`REG_ADDR_W-1:0] destE,
	output logic regWrE,
	output cpuPkg::tClassT tNewE,
	output cpuPkg::wbSrcT wbSrcE,
	output logic memWrE,
	output logic [`DATA_W-1:0] aluOutE,
	output logic [`DATA_W-1:0] storeDataE,
	output logic [`DATA_W-1:0] linkAddrE
);

	import cpuPkg::*;

	opcodeT opE;
	aluOpT aluOpE;
	logic [`DATA_W-1:0] opAE;
	logic [`DATA_W-1:0] opBE;
	logic [`DATA_W-1:0] immE;
	logic [`DATA_W-1:0] srcA;
	logic [`DATA_W-1:0] srcB;
	logic [`DATA_W-1:0] aluB;

	// Control part of the decode/execute register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rsE <= '0;
			rtE <= '0;
			destE <= '0;
			opE <= opcNop;
			aluOpE <= aluAdd;
			wbSrcE <= wbAlu;
			regWrE <= 1'b0;
			memWrE <= 1'b0;
			tNewE <= 2'd0;
		end else if (bubble) begin
			rsE <= '0;
			rtE <= '0;
			destE <= '0;
			opE <= opcNop;
			aluOpE <= aluAdd;
			wbSrcE <= wbAlu;
			regWrE <= 1'b0;
			memWrE <= 1'b0;
			tNewE <= 2'd0;
		end else begin
			rsE <= rs;
			rtE <= rt;
			destE <= dest;
			opE <= opD;
			aluOpE <= aluOp;
			wbSrcE <= wbSrc;
			regWrE <= regWr;
			memWrE <= memWr;
			tNewE <= tNew;
		end
	end

	always_ff @(posedge clk) begin
		opAE <= opA;
		opBE <= opB;
		immE <= imm32;
		linkAddrE <= linkAddr;
	end

	// Results that were not ready in decode arrive here
	assign srcA = fwdMux(fwdSelRs, opAE, memFwdVal, wbFwdVal);
	assign srcB = fwdMux(fwdSelRt, opBE, memFwdVal, wbFwdVal);

	assign aluB = (opE == opcOri || opE == opcLui || opE == opcLw || opE == opcSw) ? immE : srcB;

	always_comb begin
		case (aluOpE)
			aluSub: aluOutE = srcA - aluB;
			aluOr: aluOutE = srcA | aluB;
			aluLui: aluOutE = {aluB[15:0], 16'b0};
			default: aluOutE = srcA + aluB;
		endcase
	end

	assign storeDataE = srcB;

endmodule

// ==== logic/fetchUnit.sv ====
`timescale 1ns/10ps
`include "cpuSettings.svh"

module fetchUnit (
	input logic clk,
	input logic arstN,
	input logic stall,
	input logic branchTaken,
	input logic [`DATA_W-1:0] branchTarget,
	input logic jumpReg,
	input logic [`DATA_W-1:0] regTarget,
	output logic [`DATA_W-1:0] pc,
	output logic [`DATA_W-1:0] pcPlus4
);

	logic [`DATA_W-1:0] pcNext;

	assign pcPlus4 = pc + `DATA_W'(4);

	// jr wins over beq/j/jal, then sequential
	always_comb begin
		if (jumpReg) begin
			pcNext = regTarget;
		end else if (branchTaken) begin
			pcNext = branchTarget;
		end else begin
			pcNext = pcPlus4;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= `RESET_PC;
		end else if (!stall) begin
			pc <= pcNext;
		end
	end

	// Targets from decode must keep fetch word aligned
	pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
		else $error("fetch PC %h not word aligned", pc);

endmodule

// ==== logic/hazardUnit.sv ====
`timescale 1ns/10ps
`include "cpuSettings.svh"

module hazardUnit (
	input logic [`REG_ADDR_W-1:0] rsD,
	input logic [`REG_ADDR_W-1:0] rtD,
	input cpuPkg::tClassT tUseRs,
	input cpuPkg::tClassT tUseRt,
	input logic [`REG_ADDR_W-1:0] rsE,
	input logic [`REG_ADDR_W-1:0] rtE,
	input logic [`REG_ADDR_W-1:0] destE,
	input logic regWrE,
	input cpuPkg::tClassT tNewE,
	input logic [`REG_ADDR_W-1:0] destM,
	input logic regWrM,
	input cpuPkg::tClassT tNewM,
	input logic [`REG_ADDR_W-1:0] destW,
	input logic regWrW,
	output logic stall,
	output logic bubble,
	output cpuPkg::fwdSelT fwdSelRsD,
	output cpuPkg::fwdSelT fwdSelRtD,
	output cpuPkg::fwdSelT fwdSelRsE,
	output cpuPkg::fwdSelT fwdSelRtE
);

	import cpuPkg::*;

	logic stallRs;
	logic stallRt;

	// regWr is never set for $0, so a match implies a real register
	function automatic logic pending(
		input logic [`REG_ADDR_W-1:0] src,
		input tClassT tUse,
		input logic [`REG_ADDR_W-1:0] dst,
		input logic wr,
		input tClassT tNewX
	);
		return wr && dst == src && tUse < tNewX;
	endfunction

	function automatic fwdSelT pickSrc(
		input logic [`REG_ADDR_W-1:0] src,
		input logic [`REG_ADDR_W-1:0] dstM,
		input logic wrM,
		input tClassT tNewAtM,
		input logic [`REG_ADDR_W-1:0] dstW,
		input logic wrW
	);
		if (wrM && dstM == src && tNewAtM == 2'd0) begin
			return fwdMem;
		end
		if (wrW && dstW == src) begin
			return fwdWb;
		end
		return fwdRf;
	endfunction

	////////////////////////////////////////
	// Stall on Tuse < Tnew
	////////////////////////////////////////

	assign stallRs = pending(rsD, tUseRs, destE, regWrE, tNewE)
		|| pending(rsD, tUseRs, destM, regWrM, tNewM);
	assign stallRt = pending(rtD, tUseRt, destE, regWrE, tNewE)
		|| pending(rtD, tUseRt, destM, regWrM, tNewM);

	assign stall = stallRs || stallRt;
	// Held decode instruction must not also enter execute
	assign bubble = stall;

	////////////////////////////////////////
	// Forward selects
	////////////////////////////////////////

	assign fwdSelRsD = pickSrc(rsD, destM, regWrM, tNewM, destW, regWrW);
	assign fwdSelRtD = pickSrc(rtD, destM, regWrM, tNewM, destW, regWrW);
	assign fwdSelRsE = pickSrc(rsE, destM, regWrM, tNewM, destW, regWrW);
	assign fwdSelRtE = pickSrc(rtE, destM, regWrM, tNewM, destW, regWrW);

endmodule

// ==== logic/memWbStage.sv ====
`timescale 1ns/10ps
`include "cpuSettings.svh"

module memWbStage (
	input logic clk,
	input logic arstN,
	input logic [`REG_ADDR_W-1:0] rtE,
	input logic [`REG_ADDR_W-1:0] destE,
	input logic regWrE,
	input cpuPkg::tClassT tNewE,
	input cpuPkg::wbSrcT wbSrcE,
	input logic memWrE,
	input logic [`DATA_W-1:0] aluOutE,
	input logic [`DATA_W-1:0] storeDataE,
	input logic [`DATA_W-1:0] linkAddrE,
	input logic [`DATA_W-1:0] dataRdata,
	output logic [`DATA_W-1:0] dataAddr,
	output logic [`DATA_W-1:0] dataWdata,
	output logic dataWe,
	output logic [`REG_ADDR_W-1:0] destM,
	output logic regWrM,
	output cpuPkg::tClassT tNewM,
	output logic [`DATA_W-1:0] memFwdVal,
	output logic regWe,
	output logic [`REG_ADDR_W-1:0] regAddr,
	output logic [`DATA_W-1:0] regWdata,
	output logic [`DATA_W-1:0] wbPc
);

	import cpuPkg::*;

	logic [`REG_ADDR_W-1:0] rtM;
	wbSrcT wbSrcM;
	wbSrcT wbSrcW;
	logic [`DATA_W-1:0] storeM;
	logic [`DATA_W-1:0] linkM;
	logic [`DATA_W-1:0] aluW;
	logic [`DATA_W-1:0] memDataW;
	logic [`DATA_W-1:0] linkW;

	////////////////////////////////////////
	// Execute/memory register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rtM <= '0;
			destM <= '0;
			regWrM <= 1'b0;
			tNewM <= 2'd0;
			wbSrcM <= wbAlu;
			dataWe <= 1'b0;
		end else begin
			rtM <= rtE;
			destM <= destE;
			regWrM <= regWrE;
			// Saturates at ready
			tNewM <= (tNewE == 2'd0) ? 2'd0 : tNewE - 2'd1;
			wbSrcM <= wbSrcE;
			dataWe <= memWrE;
		end
	end

	always_ff @(posedge clk) begin
		dataAddr <= aluOutE;
		storeM <= storeDataE;
		linkM <= linkAddrE;
	end

	// A load just ahead of sw lands in writeback now
	assign dataWdata = (regWe && regAddr == rtM) ? regWdata : storeM;

	assign memFwdVal = (wbSrcM == wbLink) ? linkM : dataAddr;

	////////////////////////////////////////
	// Memory/writeback register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWe <= 1'b0;
			regAddr <= '0;
			wbSrcW <= wbAlu;
		end else begin
			regWe <= regWrM;
			regAddr <= destM;
			wbSrcW <= wbSrcM;
		end
	end

	always_ff @(posedge clk) begin
		aluW <= dataAddr;
		memDataW <= dataRdata;
		linkW <= linkM;
	end

	always_comb begin
		case (wbSrcW)
			wbMem: regWdata = memDataW;
			wbLink: regWdata = linkW;
			default: regWdata = aluW;
		endcase
	end

	// Every instruction carries PC + 8
	assign wbPc = linkW - `DATA_W'(8);

endmodule

// ==== logic/mipsCpu.sv ====
`timescale 1ns/10ps
`include "cpuSettings.svh"

module mipsCpu (
	input logic clk,
	input logic arstN,
	output logic [`DATA_W-1:0] instAddr,
	input logic [`DATA_W-1:0] instData,
	output logic [`DATA_W-1:0] dataAddr,
	output logic [`DATA_W-1:0] dataWdata,
	output logic dataWe,
	input logic [`DATA_W-1:0] dataRdata,
	output logic regWe,
	output logic [`REG_ADDR_W-1:0] regAddr,
	output logic [`DATA_W-1:0] regWdata,
	output logic [`DATA_W-1:0] wbPc
);

	import cpuPkg::*;

	logic stall;
	logic bubble;
	logic branchTaken;
	logic jumpReg;
	logic [`DATA_W-1:0] branchTarget;
	logic [`DATA_W-1:0] regTarget;
	logic [`DATA_W-1:0] pcPlus4;

	// Decode
	logic [`REG_ADDR_W-1:0] rsD;
	logic [`REG_ADDR_W-1:0] rtD;
	logic [`REG_ADDR_W-1:0] destD;
	opcodeT opD;
	aluOpT aluOpD;
	wbSrcT wbSrcD;
	logic regWrD;
	logic memWrD;
	tClassT tUseRs;
	tClassT tUseRt;
	tClassT tNewD;
	logic [`DATA_W-1:0] immD;
	logic [`DATA_W-1:0] opAD;
	logic [`DATA_W-1:0] opBD;
	logic [`DATA_W-1:0] linkD;
	logic [`DATA_W-1:0] rfRd1;
	logic [`DATA_W-1:0] rfRd2;

	// Forwarding
	fwdSelT fwdSelRsD;
	fwdSelT fwdSelRtD;
	fwdSelT fwdSelRsE;
	fwdSelT fwdSelRtE;
	logic [`DATA_W-1:0] memFwdVal;

	// Execute and memory
	logic [`REG_ADDR_W-1:0] rsE;
	logic [`REG_ADDR_W-1:0] rtE;
	logic [`REG_ADDR_W-1:0] destE;
	logic regWrE;
	tClassT tNewE;
	wbSrcT wbSrcE;
	logic memWrE;
	logic [`DATA_W-1:0] aluOutE;
	logic [`DATA_W-1:0] storeDataE;
	logic [`DATA_W-1:0] linkE;
	logic [`REG_ADDR_W-1:0] destM;
	logic regWrM;
	tClassT tNewM;

	fetchUnit i_fetchUnit (
		.clk(clk),
		.arstN(arstN),
		.stall(stall),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.jumpReg(jumpReg),
		.regTarget(regTarget),
		.pc(instAddr),
		.pcPlus4(pcPlus4)
	);

	decodeStage i_decodeStage (
		.clk(clk),
		.arstN(arstN),
		.stall(stall),
		.instData(instData),
		.pcPlus4F(pcPlus4),
		.rfRd1(rfRd1),
		.rfRd2(rfRd2),
		.fwdSel1(fwdSelRsD),
		.fwdSel2(fwdSelRtD),
		.memFwdVal(memFwdVal),
		.wbFwdVal(regWdata),
		.rs(rsD),
		.rt(rtD),
		.dest(destD),
		.opD(opD),
		.aluOp(aluOpD),
		.wbSrc(wbSrcD),
		.regWr(regWrD),
		.memWr(memWrD),
		.tUseRs(tUseRs),
		.tUseRt(tUseRt),
		.tNew(tNewD),
		.imm32(immD),
		.opA(opAD),
		.opB(opBD),
		.linkAddr(linkD),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.jumpReg(jumpReg),
		.regTarget(regTarget)
	);

	regFile i_regFile (
		.clk(clk),
		.arstN(arstN),
		.ra1(rsD),
		.ra2(rtD),
		.we(regWe),
		.wa(regAddr),
		.wd(regWdata),
		.rd1(rfRd1),
		.rd2(rfRd2)
	);

	hazardUnit i_hazardUnit (
		.rsD(rsD),
		.rtD(rtD),
		.tUseRs(tUseRs),
		.tUseRt(tUseRt),
		.rsE(rsE),
		.rtE(rtE),
		.destE(destE),
		.regWrE(regWrE),
		.tNewE(tNewE),
		.destM(destM),
		.regWrM(regWrM),
		.tNewM(tNewM),
		.destW(regAddr),
		.regWrW(regWe),
		.stall(stall),
		.bubble(bubble),
		.fwdSelRsD(fwdSelRsD),
		.fwdSelRtD(fwdSelRtD),
		.fwdSelRsE(fwdSelRsE),
		.fwdSelRtE(fwdSelRtE)
	);

	executeStage i_executeStage (
		.clk(clk),
		.arstN(arstN),
		.bubble(bubble),
		.rs(rsD),
		.rt(rtD),
		.dest(destD),
		.opD(opD),
		.aluOp(aluOpD),
		.wbSrc(wbSrcD),
		.regWr(regWrD),
		.memWr(memWrD),
		.tNew(tNewD),
		.opA(opAD),
		.opB(opBD),
		.imm32(immD),
		.linkAddr(linkD),
		.fwdSelRs(fwdSelRsE),
		.fwdSelRt(fwdSelRtE),
		.memFwdVal(memFwdVal),
		.wbFwdVal(regWdata),
		.rsE(rsE),
		.rtE(rtE),
		.destE(destE),
		.regWrE(regWrE),
		.tNewE(tNewE),
		.wbSrcE(wbSrcE),
		.memWrE(memWrE),
		.aluOutE(aluOutE),
		.storeDataE(storeDataE),
		.linkAddrE(linkE)
	);

	memWbStage i_memWbStage (
		.clk(clk),
		.arstN(arstN),
		.rtE(rtE),
		.destE(destE),
		.regWrE(regWrE),
		.tNewE(tNewE),
		.wbSrcE(wbSrcE),
		.memWrE(memWrE),
		.aluOutE(aluOutE),
		.storeDataE(storeDataE),
		.linkAddrE(linkE),
		.dataRdata(dataRdata),
		.dataAddr(dataAddr),
		.dataWdata(dataWdata),
		.dataWe(dataWe),
		.destM(destM),
		.regWrM(regWrM),
		.tNewM(tNewM),
		.memFwdVal(memFwdVal),
		.regWe(regWe),
		.regAddr(regAddr),
		.regWdata(regWdata),
		.wbPc(wbPc)
	);

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/10ps
`include "cpuSettings.svh"

module regFile (
	input logic clk,
	input logic arstN,
	input logic [`REG_ADDR_W-1:0] ra1,
	input logic [`REG_ADDR_W-1:0] ra2,
	input logic we,
	input logic [`REG_ADDR_W-1:0] wa,
	input logic [`DATA_W-1:0] wd,
	output logic [`DATA_W-1:0] rd1,
	output logic [`DATA_W-1:0] rd2
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (we) begin
			regs[wa] <= wd;
		end
	end

	// Same-cycle write returned through the bypass
	assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

	// Decode filters $0 destinations for the whole pipeline
	noZeroWrite: assert property (@(posedge clk) disable iff (!arstN) we |-> wa != '0)
		else $error("register write to zero reached the register file");

endmodule

// ==== sim/tbClock.sv ====
`timescale 1ns/10ps

module tbClock (
	output logic clk,
	output logic arstN
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset held for 5 cycles, released just after an edge
	initial begin
		arstN = 1'b0;
		repeat (5) @(posedge clk);
		#2 arstN = 1'b1;
	end

endmodule

// ==== sim/tbMipsCpu.sv ====
`timescale 1ns/10ps
`include "cpuSettings.svh"

module tbMipsCpu;

	localparam logic [31:0] END_PC = 32'h306c;

	logic clk;
	logic arstN;
	logic [31:0] instAddr;
	logic [31:0] instData;
	logic [31:0] dataAddr;
	logic [31:0] dataWdata;
	logic dataWe;
	logic [31:0] dataRdata;
	logic regWe;
	logic [4:0] regAddr;
	logic [31:0] regWdata;
	logic [31:0] wbPc;

	logic [31:0] imem [64];
	logic [31:0] dmem [256];
	logic [31:0] refMem [256];
	logic [31:0] refRf [32];

	// Expected retirements and stores from the interpreter
	logic [31:0] refPc [64];
	logic [4:0] refAddr [64];
	logic [31:0] refData [64];
	logic [31:0] refStAddr [16];
	logic [31:0] refStData [16];
	int expCount = 0;
	int stCount = 0;
	int retIdx = 0;
	int stIdx = 0;

	int retireErrors = 0;
	int storeErrors = 0;
	int otherErrors = 0;

	logic [31:0] expPc;
	logic [4:0] expAddr;
	logic [31:0] expData;
	logic [31:0] expStAddr;
	logic [31:0] expStData;

	tbClock i_tbClock (
		.clk(clk),
		.arstN(arstN)
	);

	mipsCpu i_mipsCpu (
		.clk(clk),
		.arstN(arstN),
		.instAddr(instAddr),
		.instData(instData),
		.dataAddr(dataAddr),
		.dataWdata(dataWdata),
		.dataWe(dataWe),
		.dataRdata(dataRdata),
		.regWe(regWe),
		.regAddr(regAddr),
		.regWdata(regWdata),
		.wbPc(wbPc)
	);

	////////////////////////////////////////
	// Memory models
	////////////////////////////////////////

	function automatic logic [5:0] instIndex(input logic [31:0] addr);
		logic [31:0] offs;
		offs = (addr - `RESET_PC) >> 2;
		return offs[5:0];
	endfunction

	// Outside the program fetches read as no-ops
	assign instData = (instAddr >= `RESET_PC && instAddr < `RESET_PC + 32'd256)
		? imem[instIndex(instAddr)] : 32'h0;

	assign dataRdata = dmem[dataAddr[9:2]];

	always @(posedge clk) begin
		if (dataWe) begin
			dmem[dataAddr[9:2]] <= dataWdata;
		end
	end

	function automatic logic [31:0] fillWord(input logic [31:0] addr);
		return (addr * 32'h9e3779b1) ^ 32'h0badf00d;
	endfunction

	function automatic logic [31:0] nextRandom(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////

	function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jType(input logic [5:0] op, input logic [31:0] target);
		return {op, target[27:2]};
	endfunction

	task automatic loadProgram();
		logic [31:0] rnd;
		logic [15:0] imm [4];
		rnd = 32'h1fa3;
		for (int i = 0; i < 4; i++) begin
			rnd = nextRandom(rnd);
			imm[i] = rnd[15:0];
		end
		for (int i = 0; i < 64; i++) begin
			imem[i] = 32'h0;
		end
		// Dependent ALU chain
		imem[0] = iType(6'h0f, 5'd0, 5'd1, imm[0]);
		imem[1] = iType(6'h0d, 5'd1, 5'd2, imm[1]);
		imem[2] = rType(5'd2, 5'd1, 5'd3, 6'h21);
		imem[3] = rType(5'd3, 5'd2, 5'd4, 6'h23);
		imem[4] = iType(6'h0d, 5'd4, 5'd5, imm[2]);
		imem[5] = iType(6'h0f, 5'd0, 5'd6, imm[3]);
		imem[6] = rType(5'd6, 5'd5, 5'd7, 6'h21);
		// Load-use, then stores fed by the previous instruction
		imem[7] = iType(6'h0d, 5'd0, 5'd8, 16'h0040);
		imem[8] = iType(6'h23, 5'd8, 5'd9, 16'h0004);
		imem[9] = rType(5'd9, 5'd7, 5'd10, 6'h21);
		imem[10] = rType(5'd10, 5'd3, 5'd11, 6'h21);
		imem[11] = iType(6'h2b, 5'd8, 5'd11, 16'h0008);
		imem[12] = iType(6'h23, 5'd8, 5'd12, 16'h0008);
		imem[13] = iType(6'h2b, 5'd8, 5'd12, 16'h000c);
		// Taken beq, then not taken, then lw feeding beq
		imem[14] = rType(5'd12, 5'd11, 5'd13, 6'h23);
		imem[15] = iType(6'h04, 5'd13, 5'd0, 16'h0002);
		imem[16] = iType(6'h0d, 5'd0, 5'd14, 16'h0011);
		imem[17] = iType(6'h0d, 5'd0, 5'd15, 16'h0022);
		imem[18] = iType(6'h0d, 5'd5, 5'd16, 16'h0033);
		imem[19] = iType(6'h04, 5'd16, 5'd0, 16'h0005);
		imem[20] = iType(6'h0d, 5'd0, 5'd17, 16'h0044);
		imem[21] = iType(6'h23, 5'd8, 5'd18, 16'h0004);
		imem[22] = iType(6'h04, 5'd18, 5'd9, 16'h0001);
		imem[23] = rType(5'd18, 5'd16, 5'd19, 6'h21);
		// Call and return
		imem[24] = jType(6'h03, 32'h3080);
		imem[25] = iType(6'h0d, 5'd0, 5'd20, 16'h0055);
		imem[26] = rType(5'd31, 5'd20, 5'd21, 6'h21);
		imem[27] = iType(6'h04, 5'd0, 5'd0, 16'hffff);
		imem[32] = iType(6'h0d, 5'd31, 5'd22, 16'h0000);
		imem[33] = rType(5'd31, 5'd0, 5'd0, 6'h08);
		imem[34] = rType(5'd22, 5'd1, 5'd23, 6'h21);
	endtask

	////////////////////////////////////////
	// Reference interpreter
	////////////////////////////////////////

	task automatic runReference();
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] newNpc;
		logic [31:0] w;
		logic [31:0] val;
		logic [31:0] sext;
		logic [31:0] ea;
		logic [4:0] dst;
		logic wr;
		int steps;
		for (int i = 0; i < 32; i++) begin
			refRf[i] = 32'h0;
		end
		pc = `RESET_PC;
		npc = pc + 32'd4;
		steps = 0;
		while (pc != END_PC && steps < 200) begin
			w = imem[instIndex(pc)];
			sext = {{16{w[15]}}, w[15:0]};
			ea = refRf[w[25:21]] + sext;
			newNpc = npc + 32'd4;
			wr = 1'b0;
			dst = w[20:16];
			val = 32'h0;
			case (w[31:26])
				6'h00: begin
					if (w[5:0] == 6'h21) begin
						val = refRf[w[25:21]] + refRf[w[20:16]];
						dst = w[15:11];
						wr = 1'b1;
					end else if (w[5:0] == 6'h23) begin
						val = refRf[w[25:21]] - refRf[w[20:16]];
						dst = w[15:11];
						wr = 1'b1;
					end else if (w[5:0] == 6'h08) begin
						newNpc = refRf[w[25:21]];
					end
				end
				6'h0d: begin
					val = refRf[w[25:21]] | {16'h0, w[15:0]};
					wr = 1'b1;
				end
				6'h0f: begin
					val = {w[15:0], 16'h0};
					wr = 1'b1;
				end
				6'h23: begin
					val = refMem[ea[9:2]];
					wr = 1'b1;
				end
				6'h2b: begin
					refMem[ea[9:2]] = refRf[w[20:16]];
					refStAddr[stCount] = ea;
					refStData[stCount] = refRf[w[20:16]];
					stCount++;
				end
				6'h04: begin
					if (refRf[w[25:21]] == refRf[w[20:16]]) begin
						newNpc = pc + 32'd4 + {sext[29:0], 2'b00};
					end
				end
				6'h02: newNpc = {npc[31:28], w[25:0], 2'b00};
				6'h03: begin
					newNpc = {npc[31:28], w[25:0], 2'b00};
					val = pc + 32'd8;
					dst = `LINK_REG;
					wr = 1'b1;
				end
				default: ;
			endcase
			if (wr && dst != 5'd0) begin
				refRf[dst] = val;
				refPc[expCount] = pc;
				refAddr[expCount] = dst;
				refData[expCount] = val;
				expCount++;
			end
			pc = npc;
			npc = newNpc;
			steps++;
		end
	endtask

	////////////////////////////////////////
	// Checking
	////////////////////////////////////////

	assign expPc = (retIdx < expCount) ? refPc[retIdx[5:0]] : 32'h0;
	assign expAddr = (retIdx < expCount) ? refAddr[retIdx[5:0]] : 5'd0;
	assign expData = (retIdx < expCount) ? refData[retIdx[5:0]] : 32'h0;
	assign expStAddr = (stIdx < stCount) ? refStAddr[stIdx[3:0]] : 32'h0;
	assign expStData = (stIdx < stCount) ? refStData[stIdx[3:0]] : 32'h0;

	always @(posedge clk) begin
		if (arstN && regWe) begin
			retIdx <= retIdx + 1;
		end
		if (arstN && dataWe) begin
			stIdx <= stIdx + 1;
		end
	end

	resetQuiet: assert property (@(posedge clk) !arstN |-> !regWe && !dataWe)
		else begin
			otherErrors = otherErrors + 1;
			$display("Write strobe active during reset");
		end

	pcAfterReset: assert property (@(posedge clk) $rose(arstN) |-> instAddr == `RESET_PC)
		else begin
			otherErrors = otherErrors + 1;
			$display("Mismatch instAddr: got %h expected %h", $sampled(instAddr), `RESET_PC);
		end

	retireExtra: assert property (@(posedge clk) disable iff (!arstN)
		regWe |-> retIdx < expCount)
		else begin
			otherErrors = otherErrors + 1;
			$display("Register write after the last expected retirement");
		end

	retirePc: assert property (@(posedge clk) disable iff (!arstN) regWe |-> wbPc == expPc)
		else begin
			retireErrors = retireErrors + 1;
			$display("Mismatch wbPc: got %h expected %h", $sampled(wbPc), $sampled(expPc));
		end

	retireAddr: assert property (@(posedge clk) disable iff (!arstN)
		regWe |-> regAddr == expAddr)
		else begin
			retireErrors = retireErrors + 1;
			$display("Mismatch regAddr: got %h expected %h", $sampled(regAddr),
				$sampled(expAddr));
		end

	retireData: assert property (@(posedge clk) disable iff (!arstN)
		regWe |-> regWdata == expData)
		else begin
			retireErrors = retireErrors + 1;
			$display("Mismatch regWdata: got %h expected %h", $sampled(regWdata),
				$sampled(expData));
		end

	// Only real stores may raise dataWe
	storeExtra: assert property (@(posedge clk) disable iff (!arstN)
		dataWe |-> stIdx < stCount)
		else begin
			storeErrors = storeErrors + 1;
			$display("Data write strobe without an expected store");
		end

	storeAddr: assert property (@(posedge clk) disable iff (!arstN)
		dataWe |-> dataAddr == expStAddr)
		else begin
			storeErrors = storeErrors + 1;
			$display("Mismatch dataAddr: got %h expected %h", $sampled(dataAddr),
				$sampled(expStAddr));
		end

	storeData: assert property (@(posedge clk) disable iff (!arstN)
		dataWe |-> dataWdata == expStData)
		else begin
			storeErrors = storeErrors + 1;
			$display("Mismatch dataWdata: got %h expected %h", $sampled(dataWdata),
				$sampled(expStData));
		end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int cycles;
		int total;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = fillWord({22'h0, i[7:0], 2'b00});
			refMem[i] = dmem[i];
		end
		loadProgram();
		runReference();

		cycles = 0;
		while (!arstN && cycles < 20) begin
			@(posedge clk);
			cycles++;
		end
		if (!arstN) begin
			otherErrors = otherErrors + 1;
			$display("Reset was never released");
		end

		cycles = 0;
		while ((retIdx < expCount || stIdx < stCount) && cycles < 1000) begin
			@(posedge clk);
			cycles++;
		end
		if (retIdx < expCount || stIdx < stCount) begin
			otherErrors = otherErrors + 1;
			$display("Timeout after %0d retirements of %0d and %0d stores of %0d",
				retIdx, expCount, stIdx, stCount);
		end

		// Let any stray write show up
		cycles = 0;
		while (cycles < 10) begin
			@(posedge clk);
			cycles++;
		end

		total = retireErrors + storeErrors + otherErrors;
		$display("Errors: retire %0d, store %0d, other %0d", retireErrors, storeErrors,
			otherErrors);
		if (total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
